//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_debug_jtag
FILELIST  := list.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
verilog/jtag_pkg.sv
verilog/dbg_reg_pkg.sv
verilog/jtag_ctl_if.sv
verilog/cfg_bus_if.sv
verilog/jtag_pin_sync.sv
verilog/jtag_tap_ctrl.sv
verilog/jtag_dr_chain.sv
verilog/debug_reg_file.sv
verilog/debug_jtag_top.sv
verification/tb_debug_jtag.sv

//--- verification/debug_jtag_testdata.txt
# One command per line, fields in hex except the B bit count (decimal)
# I idcode | B opcode bits | S adc_avg pfd_offset sram_data | W addr data | R addr expected
# O afe_ctl dcore_ctl cdr_i cdr_p sram_addr rstb(cdr,sram,afe) | T (TAP reset with trst_n low)
O 0000 0000 00 00 000 0
I 1D0C0A5F
B F 32
B 5 40
B 0 17
S 1234 ABCD 5A5A
W 0 BEEF
W 1 0F0F
W 2 3C81
W 3 FFFF
O BEEF 0F0F 3C 81 3FF 0
W 4 0001
O BEEF 0F0F 3C 81 3FF 1
W 4 0006
O BEEF 0F0F 3C 81 3FF 6
W 4 0007
O BEEF 0F0F 3C 81 3FF 7
R 0 BEEF
R 2 3C81
R 3 FFFF
R 4 0007
R 8 1234
R 9 ABCD
R A 5A5A
S 0F1E 2D3C 4B5A
W 8 FFFF
W 9 0000
W A 1111
W 5 DEAD
W F 7777
R 8 0F1E
R 9 2D3C
R A 4B5A
R 5 0000
R F 0000
O BEEF 0F0F 3C 81 3FF 7
T
I 1D0C0A5F
R 1 0F0F
O BEEF 0F0F 3C 81 3FF 7
W 1 A5C3
R 1 A5C3
B F 24

//--- verification/tb_debug_jtag.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_jtag
	import jtag_pkg::*;
	import dbg_reg_pkg::*;
();
	localparam int         HALF_TCK      = 8;
	localparam int         TCK_CLKS      = 2 * HALF_TCK;
	localparam int         TICKS_PER_CMD = 70;
	localparam int         EOL_CHAR      = 10;
	localparam string      DATA_FILE     = "verification/debug_jtag_testdata.txt";
	localparam logic [3:0] IR_CAPTURE_EXP = 4'b0001;

	logic                       clk;
	logic                       rst_n;
	logic                       tck;
	logic                       tms;
	logic                       tdi;
	logic                       trst_n;
	dbg_data_t                  adc_avg;
	dbg_data_t                  pfd_offset;
	dbg_data_t                  sram_data;
	logic                       tdo;
	dbg_data_t                  afe_ctl;
	logic                       afe_rstb;
	dbg_data_t                  dcore_ctl;
	logic [CDR_GAIN_WIDTH-1:0]  cdr_i_val;
	logic [CDR_GAIN_WIDTH-1:0]  cdr_p_val;
	logic                       cdr_rstb;
	logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
	logic                       sram_rstb;

	// Six argument words per command
	logic [7:0]  op_q [$];
	logic [31:0] arg_q [$];
	int          cycle_count = 0;
	int          timeout_limit = 0;

	debug_jtag_top dut0 (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.tck_i       (tck),
		.tms_i       (tms),
		.tdi_i       (tdi),
		.trst_n_i    (trst_n),
		.adc_avg_i   (adc_avg),
		.pfd_offset_i(pfd_offset),
		.sram_data_i (sram_data),
		.tdo_o       (tdo),
		.afe_ctl_o   (afe_ctl),
		.afe_rstb_o  (afe_rstb),
		.dcore_ctl_o (dcore_ctl),
		.cdr_i_val_o (cdr_i_val),
		.cdr_p_val_o (cdr_p_val),
		.cdr_rstb_o  (cdr_rstb),
		.sram_addr_o (sram_addr),
		.sram_rstb_o (sram_rstb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_idcode(input idcode_t act, input idcode_t exp);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] idcode: got %h, expected %h", act, exp));
		end
	endtask

	task automatic check_word(input string name, input dbg_data_t act, input dbg_data_t exp);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, act, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, act, exp));
		end
	endtask

	task automatic check_outputs(
		input dbg_data_t                  exp_afe,
		input dbg_data_t                  exp_dcore,
		input logic [CDR_GAIN_WIDTH-1:0]  exp_i_val,
		input logic [CDR_GAIN_WIDTH-1:0]  exp_p_val,
		input logic [SRAM_ADDR_WIDTH-1:0] exp_sram_addr,
		input logic [2:0]                 exp_rstb
	);
		check_word("afe_ctl_o", afe_ctl, exp_afe);
		check_word("dcore_ctl_o", dcore_ctl, exp_dcore);
		check_word("cdr_i_val_o", dbg_data_t'(cdr_i_val), dbg_data_t'(exp_i_val));
		check_word("cdr_p_val_o", dbg_data_t'(cdr_p_val), dbg_data_t'(exp_p_val));
		check_word("sram_addr_o", dbg_data_t'(sram_addr), dbg_data_t'(exp_sram_addr));
		check_bit("afe_rstb_o", afe_rstb, exp_rstb[RST_INT_BIT]);
		check_bit("sram_rstb_o", sram_rstb, exp_rstb[RST_SRAM_BIT]);
		check_bit("cdr_rstb_o", cdr_rstb, exp_rstb[RST_CDR_BIT]);
	endtask

	// One TCK period, TDO taken at the end of the low phase
	task automatic tick(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (HALF_TCK - 1) @(posedge clk);
		tdo_v = tdo;
		@(posedge clk);
		tck <= 1'b1;
		repeat (HALF_TCK - 1) @(posedge clk);
	endtask

	task automatic goto_reset(input logic use_trst);
		logic b;
		@(posedge clk);
		trst_n <= ~use_trst;
		repeat (5) tick(1'b1, 1'b0, b);
		@(posedge clk);
		trst_n <= 1'b1;
		tick(1'b0, 1'b0, b);
	endtask

	// Starts and ends in Run-Test-Idle
	task automatic scan_ir(input logic [IR_WIDTH-1:0] code);
		logic                b;
		logic [IR_WIDTH-1:0] cap;
		tick(1'b1, 1'b0, b);
		tick(1'b1, 1'b0, b);
		tick(1'b0, 1'b0, b);
		tick(1'b0, 1'b0, b);
		for (int i = 0; i < IR_WIDTH; i++) begin
			tick(i == IR_WIDTH - 1, code[i], b);
			cap[i] = b;
		end
		tick(1'b1, 1'b0, b);
		tick(1'b0, 1'b0, b);
		check_word("ir_capture", dbg_data_t'(cap), dbg_data_t'(IR_CAPTURE_EXP));
	endtask

	task automatic scan_dr(input int bits, input logic [63:0] din, output logic [63:0] dout);
		logic b;
		dout = '0;
		tick(1'b1, 1'b0, b);
		tick(1'b0, 1'b0, b);
		tick(1'b0, 1'b0, b);
		for (int i = 0; i < bits; i++) begin
			tick(i == bits - 1, din[i], b);
			dout[i] = b;
		end
		tick(1'b1, 1'b0, b);
		tick(1'b0, 1'b0, b);
	endtask

	task automatic bypass_scan(input logic [IR_WIDTH-1:0] code, input int bits);
		logic [63:0] pattern;
		logic [63:0] dout;
		pattern = {$urandom, $urandom};
		scan_ir(code);
		scan_dr(bits, pattern, dout);
		// Captured 0 comes out first, then the pattern one bit late
		for (int i = 0; i < bits; i++) begin
			check_bit($sformatf("tdo_o bit %0d", i), dout[i], (i == 0) ? 1'b0 : pattern[i-1]);
		end
	endtask

	task automatic cfg_write(input logic [3:0] addr, input dbg_data_t data);
		logic [63:0] dout;
		scan_ir(INSTR_CFG_ACCESS);
		scan_dr(CFG_DR_WIDTH, {43'd0, 1'b1, addr, data}, dout);
	endtask

	task automatic cfg_read(input logic [3:0] addr, input dbg_data_t exp);
		logic [63:0] dout;
		scan_ir(INSTR_CFG_ACCESS);
		// Address scan, then data scan
		scan_dr(CFG_DR_WIDTH, {44'd0, addr, 16'h0000}, dout);
		scan_dr(CFG_DR_WIDTH, {44'd0, addr, 16'h0000}, dout);
		check_bit("cfg_wr", dout[20], 1'b0);
		check_word("cfg_addr", dbg_data_t'(dout[19:16]), dbg_data_t'(addr));
		check_word("cfg_rdata", dout[15:0], exp);
	endtask

	task automatic set_status(input dbg_data_t adc, input dbg_data_t pfd, input dbg_data_t sram);
		@(posedge clk);
		adc_avg    <= adc;
		pfd_offset <= pfd;
		sram_data  <= sram;
	endtask

	task automatic read_commands();
		int          fd;
		int          got;
		int          need;
		int          ch;
		logic [7:0]  op;
		logic [31:0] a0, a1, a2, a3, a4, a5;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			abort_run({"cannot open the data file ", DATA_FILE});
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			{a0, a1, a2, a3, a4, a5} = '0;
			if (op == "#") begin
				ch = $fgetc(fd);
				while (ch != EOL_CHAR && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				case (op)
					"I": begin need = 1; got = $fscanf(fd, "%h", a0); end
					"B": begin need = 2; got = $fscanf(fd, "%h %d", a0, a1); end
					"S": begin need = 3; got = $fscanf(fd, "%h %h %h", a0, a1, a2); end
					"W": begin need = 2; got = $fscanf(fd, "%h %h", a0, a1); end
					"R": begin need = 2; got = $fscanf(fd, "%h %h", a0, a1); end
					"O": begin
						need = 6;
						got = $fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
					end
					"T": begin need = 0; got = 0; end
					default: begin need = 0; got = -1; end
				endcase
				if (got != need) begin
					abort_run($sformatf("data file has an unknown or broken command %c", op));
				end
				op_q.push_back(op);
				arg_q.push_back(a0);
				arg_q.push_back(a1);
				arg_q.push_back(a2);
				arg_q.push_back(a3);
				arg_q.push_back(a4);
				arg_q.push_back(a5);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_command(input int idx);
		logic [7:0]  op;
		logic [31:0] a [6];
		logic [63:0] dout;
		op = op_q[idx];
		for (int k = 0; k < 6; k++) begin
			a[k] = arg_q[6 * idx + k];
		end
		case (op)
			"I": begin
				scan_dr(32, 64'd0, dout);
				check_idcode(dout[31:0], a[0]);
			end
			"B": bypass_scan(a[0][3:0], int'(a[1]));
			"S": set_status(a[0][15:0], a[1][15:0], a[2][15:0]);
			"W": cfg_write(a[0][3:0], a[1][15:0]);
			"R": cfg_read(a[0][3:0], a[1][15:0]);
			"O": check_outputs(a[0][15:0], a[1][15:0], a[2][CDR_GAIN_WIDTH-1:0],
				a[3][CDR_GAIN_WIDTH-1:0], a[4][SRAM_ADDR_WIDTH-1:0], a[5][2:0]);
			"T": goto_reset(1'b1);
			default: abort_run($sformatf("no handler for command %c", op));
		endcase
	endtask

	initial begin : watchdog
		wait (timeout_limit != 0);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		abort_run($sformatf("timeout after %0d clock cycles", timeout_limit));
	end

	initial begin
		void'($urandom(32'h2b1c56cc));
		rst_n      <= 1'b0;
		tck        <= 1'b0;
		tms        <= 1'b1;
		tdi        <= 1'b0;
		trst_n     <= 1'b1;
		adc_avg    <= '0;
		pfd_offset <= '0;
		sram_data  <= '0;
		read_commands();
		timeout_limit = op_q.size() * TICKS_PER_CMD * TCK_CLKS;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_bit("tdo_o", tdo, 1'b0);
		// TLR to Run-Test-Idle, no IR scan
		goto_reset(1'b0);
		for (int i = 0; i < op_q.size(); i++) begin
			run_command(i);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cfg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cfg_bus_if
	import dbg_reg_pkg::*;
();
	logic      wr_en;
	dbg_addr_t addr;
	dbg_data_t wdata;
	// Combinational read of addr
	dbg_data_t rdata;

	modport master (
		output wr_en,
		output addr,
		output wdata,
		input  rdata
	);

	modport slave (
		input  wr_en,
		input  addr,
		input  wdata,
		output rdata
	);
endinterface

`default_nettype wire

//--- verilog/dbg_reg_pkg.sv
`default_nettype none

package dbg_reg_pkg;

	// Addresses 8 and up are read-only status
	typedef enum logic [3:0] {
		ANALOG_CTL = 4'd0,
		DCORE_CTL  = 4'd1,
		CDR_GAIN   = 4'd2,
		SRAM_ADDR  = 4'd3,
		RESET_CTL  = 4'd4,
		ADC_AVG    = 4'd8,
		PFD_OFFSET = 4'd9,
		SRAM_DATA  = 4'd10
	} dbg_addr_t;

	typedef logic [15:0] dbg_data_t;

	localparam int CFG_DR_WIDTH = 21;

	// Scan word layout, MSB first
	typedef struct packed {
		logic      wr;
		dbg_addr_t addr;
		dbg_data_t data;
	} cfg_dr_t;

	localparam int CDR_GAIN_WIDTH = 8;

	typedef struct packed {
		logic [CDR_GAIN_WIDTH-1:0] i_val;
		logic [CDR_GAIN_WIDTH-1:0] p_val;
	} cdr_gain_t;

	// RESET_CTL bits, active low component resets
	localparam int RST_INT_BIT  = 0;
	localparam int RST_SRAM_BIT = 1;
	localparam int RST_CDR_BIT  = 2;

	localparam int SRAM_ADDR_WIDTH = 10;

endpackage

`default_nettype wire

//--- verilog/debug_jtag_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_jtag_top
	import jtag_pkg::*;
	import dbg_reg_pkg::*;
#(
	parameter int      SYNC_STAGES = 2,
	parameter idcode_t IDCODE      = DEFAULT_IDCODE
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  tck_i,
	input  wire logic                  tms_i,
	input  wire logic                  tdi_i,
	input  wire logic                  trst_n_i,
	input  wire dbg_data_t             adc_avg_i,
	input  wire dbg_data_t             pfd_offset_i,
	input  wire dbg_data_t             sram_data_i,
	output logic                       tdo_o,
	output dbg_data_t                  afe_ctl_o,
	output logic                       afe_rstb_o,
	output dbg_data_t                  dcore_ctl_o,
	output logic [CDR_GAIN_WIDTH-1:0]  cdr_i_val_o,
	output logic [CDR_GAIN_WIDTH-1:0]  cdr_p_val_o,
	output logic                       cdr_rstb_o,
	output logic [SRAM_ADDR_WIDTH-1:0] sram_addr_o,
	output logic                       sram_rstb_o
);
	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_n_s;
	logic ir_tdo;
	logic ir_sel;

	jtag_ctl_if ctl_if ();
	cfg_bus_if  cfg_if ();

	jtag_pin_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) pin_sync0 (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.tck_i     (tck_i),
		.tms_i     (tms_i),
		.tdi_i     (tdi_i),
		.trst_n_i  (trst_n_i),
		.tck_rise_o(tck_rise),
		.tck_fall_o(tck_fall),
		.tms_o     (tms_s),
		.tdi_o     (tdi_s),
		.trst_n_o  (trst_n_s)
	);

	jtag_tap_ctrl tap0 (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.tck_rise_i(tck_rise),
		.tck_fall_i(tck_fall),
		.tms_i     (tms_s),
		.tdi_i     (tdi_s),
		.trst_n_i  (trst_n_s),
		.ctl       (ctl_if.tap),
		.ir_tdo_o  (ir_tdo),
		.ir_sel_o  (ir_sel)
	);

	jtag_dr_chain #(
		.IDCODE(IDCODE)
	) chain0 (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ctl     (ctl_if.chain),
		.cfg     (cfg_if.master),
		.ir_tdo_i(ir_tdo),
		.ir_sel_i(ir_sel),
		.tdo_o   (tdo_o)
	);

	debug_reg_file regs0 (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.cfg         (cfg_if.slave),
		.adc_avg_i   (adc_avg_i),
		.pfd_offset_i(pfd_offset_i),
		.sram_data_i (sram_data_i),
		.afe_ctl_o   (afe_ctl_o),
		.afe_rstb_o  (afe_rstb_o),
		.dcore_ctl_o (dcore_ctl_o),
		.cdr_i_val_o (cdr_i_val_o),
		.cdr_p_val_o (cdr_p_val_o),
		.cdr_rstb_o  (cdr_rstb_o),
		.sram_addr_o (sram_addr_o),
		.sram_rstb_o (sram_rstb_o)
	);

endmodule

`default_nettype wire

//--- verilog/debug_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module debug_reg_file
	import dbg_reg_pkg::*;
(
	input  wire logic                       clk_i,
	input  wire logic                       rst_n_i,
	cfg_bus_if.slave                        cfg,
	input  wire dbg_data_t                  adc_avg_i,
	input  wire dbg_data_t                  pfd_offset_i,
	input  wire dbg_data_t                  sram_data_i,
	output dbg_data_t                       afe_ctl_o,
	output logic                            afe_rstb_o,
	output dbg_data_t                       dcore_ctl_o,
	output logic [CDR_GAIN_WIDTH-1:0]       cdr_i_val_o,
	output logic [CDR_GAIN_WIDTH-1:0]       cdr_p_val_o,
	output logic                            cdr_rstb_o,
	output logic [SRAM_ADDR_WIDTH-1:0]      sram_addr_o,
	output logic                            sram_rstb_o
);
	dbg_data_t analog_q;
	dbg_data_t dcore_q;
	cdr_gain_t cdr_gain_q;
	dbg_data_t sram_addr_q;
	dbg_data_t reset_ctl_q;

	// Status addresses and holes drop writes
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			analog_q    <= '0;
			dcore_q     <= '0;
			cdr_gain_q  <= '0;
			sram_addr_q <= '0;
			reset_ctl_q <= '0;
		end else if (cfg.wr_en) begin
			case (cfg.addr)
				ANALOG_CTL: analog_q <= cfg.wdata;
				DCORE_CTL:  dcore_q <= cfg.wdata;
				CDR_GAIN:   cdr_gain_q <= cdr_gain_t'(cfg.wdata);
				SRAM_ADDR:  sram_addr_q <= cfg.wdata;
				RESET_CTL:  reset_ctl_q <= cfg.wdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (cfg.addr)
			ANALOG_CTL: cfg.rdata = analog_q;
			DCORE_CTL:  cfg.rdata = dcore_q;
			CDR_GAIN:   cfg.rdata = dbg_data_t'(cdr_gain_q);
			SRAM_ADDR:  cfg.rdata = sram_addr_q;
			RESET_CTL:  cfg.rdata = reset_ctl_q;
			ADC_AVG:    cfg.rdata = adc_avg_i;
			PFD_OFFSET: cfg.rdata = pfd_offset_i;
			SRAM_DATA:  cfg.rdata = sram_data_i;
			default:    cfg.rdata = '0;
		endcase
	end

	assign afe_ctl_o   = analog_q;
	assign dcore_ctl_o = dcore_q;
	assign cdr_i_val_o = cdr_gain_q.i_val;
	assign cdr_p_val_o = cdr_gain_q.p_val;
	assign sram_addr_o = sram_addr_q[SRAM_ADDR_WIDTH-1:0];

	// Component held in reset by chip reset or its own bit
	assign afe_rstb_o  = rst_n_i && reset_ctl_q[RST_INT_BIT];
	assign sram_rstb_o = rst_n_i && reset_ctl_q[RST_SRAM_BIT];
	assign cdr_rstb_o  = rst_n_i && reset_ctl_q[RST_CDR_BIT];

endmodule

`default_nettype wire

//--- verilog/jtag_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface jtag_ctl_if
	import jtag_pkg::*;
();
	logic        tck_rise;
	logic        tck_fall;
	logic        tdi;
	// Strobes only valid together with tck_rise
	logic        capture_dr;
	logic        shift_dr;
	logic        update_dr;
	jtag_instr_t instr;

	modport tap (
		output tck_rise,
		output tck_fall,
		output tdi,
		output capture_dr,
		output shift_dr,
		output update_dr,
		output instr
	);

	modport chain (
		input tck_rise,
		input tck_fall,
		input tdi,
		input capture_dr,
		input shift_dr,
		input update_dr,
		input instr
	);
endinterface

`default_nettype wire

//--- verilog/jtag_dr_chain.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_dr_chain
	import jtag_pkg::*;
	import dbg_reg_pkg::*;
#(
	parameter idcode_t IDCODE = DEFAULT_IDCODE
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	jtag_ctl_if.chain ctl,
	cfg_bus_if.master cfg,
	input  wire logic ir_tdo_i,
	input  wire logic ir_sel_i,
	output logic      tdo_o
);
	idcode_t                 idcode_q;
	logic                    bypass_q;
	logic [CFG_DR_WIDTH-1:0] cfg_shift_q;
	cfg_dr_t                 cfg_scan;
	dbg_addr_t               addr_q;
	dbg_data_t               wdata_q;
	logic                    wr_en_q;
	logic                    dr_active_q;
	logic                    dr_tdo;

	assign cfg_scan = cfg_dr_t'(cfg_shift_q);

	// Data registers shift right, TDI enters at the MSB
	always_ff @(posedge clk_i) begin
		if (ctl.capture_dr) begin
			idcode_q    <= IDCODE;
			bypass_q    <= 1'b0;
			cfg_shift_q <= {1'b0, addr_q, cfg.rdata};
		end else if (ctl.shift_dr) begin
			case (ctl.instr)
				INSTR_IDCODE: begin
					idcode_q <= {ctl.tdi, idcode_q[$bits(idcode_t)-1:1]};
				end
				INSTR_CFG_ACCESS: begin
					cfg_shift_q <= {ctl.tdi, cfg_shift_q[CFG_DR_WIDTH-1:1]};
				end
				default: begin
					bypass_q <= ctl.tdi;
				end
			endcase
		end else if (ctl.update_dr) begin
			wdata_q <= cfg_scan.data;
		end
	end

	// Address stays latched for the capture of the next scan
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_q  <= ANALOG_CTL;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= 1'b0;
			if (ctl.update_dr && ctl.instr == INSTR_CFG_ACCESS) begin
				addr_q  <= cfg_scan.addr;
				wr_en_q <= cfg_scan.wr;
			end
		end
	end

	assign cfg.wr_en = wr_en_q;
	assign cfg.addr  = addr_q;
	assign cfg.wdata = wdata_q;

	always_comb begin
		case (ctl.instr)
			INSTR_IDCODE:     dr_tdo = idcode_q[0];
			INSTR_CFG_ACCESS: dr_tdo = cfg_shift_q[0];
			default:          dr_tdo = bypass_q;
		endcase
	end

	// TDO launched on the falling TCK edge
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dr_active_q <= 1'b0;
			tdo_o       <= 1'b0;
		end else begin
			if (ctl.capture_dr) begin
				dr_active_q <= 1'b1;
			end else if (ctl.update_dr) begin
				dr_active_q <= 1'b0;
			end
			if (ctl.tck_fall) begin
				if (ir_sel_i) begin
					tdo_o <= ir_tdo_i;
				end else if (dr_active_q) begin
					tdo_o <= dr_tdo;
				end else begin
					tdo_o <= 1'b0;
				end
			end
		end
	end

	a_wr_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cfg.wr_en |=> !cfg.wr_en);

	// Strobes from the TAP only ride on a TCK rise
	a_strobe_on_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ctl.capture_dr || ctl.shift_dr || ctl.update_dr) |-> ctl.tck_rise);

endmodule

`default_nettype wire

//--- verilog/jtag_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_pin_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic      tck_rise_o,
	output logic      tck_fall_o,
	output logic      tms_o,
	output logic      tdi_o,
	output logic      trst_n_o
);
	localparam int PIN_TCK  = 0;
	localparam int PIN_TMS  = 1;
	localparam int PIN_TDI  = 2;
	localparam int PIN_TRST = 3;

	// Idle levels: trst_n high, tdi low, tms high, tck low
	localparam logic [3:0] PIN_IDLE = 4'b1010;

	logic [3:0] pins;
	logic [3:0] pin_s;
	logic [3:0] sync_q [SYNC_STAGES];
	logic       tck_q;

	assign pins = {trst_n_i, tdi_i, tms_i, tck_i};
	assign pin_s = sync_q[SYNC_STAGES-1];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= PIN_IDLE;
			end
			tck_q      <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
			tms_o      <= 1'b1;
			tdi_o      <= 1'b0;
			trst_n_o   <= 1'b1;
		end else begin
			sync_q[0] <= pins;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			// Edge detect, other pins delayed to stay aligned with it
			tck_q      <= pin_s[PIN_TCK];
			tck_rise_o <= pin_s[PIN_TCK] & ~tck_q;
			tck_fall_o <= ~pin_s[PIN_TCK] & tck_q;
			tms_o      <= pin_s[PIN_TMS];
			tdi_o      <= pin_s[PIN_TDI];
			trst_n_o   <= pin_s[PIN_TRST];
		end
	end

	// An edge strobe is never followed by another in the next clock
	a_edges_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(tck_rise_o || tck_fall_o) |=> !(tck_rise_o || tck_fall_o));

endmodule

`default_nettype wire

//--- verilog/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

	// IEEE 1149.1 TAP controller states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET = 4'h0,
		RUN_TEST_IDLE    = 4'h1,
		SELECT_DR_SCAN   = 4'h2,
		CAPTURE_DR       = 4'h3,
		SHIFT_DR         = 4'h4,
		EXIT1_DR         = 4'h5,
		PAUSE_DR         = 4'h6,
		EXIT2_DR         = 4'h7,
		UPDATE_DR        = 4'h8,
		SELECT_IR_SCAN   = 4'h9,
		CAPTURE_IR       = 4'ha,
		SHIFT_IR         = 4'hb,
		EXIT1_IR         = 4'hc,
		PAUSE_IR         = 4'hd,
		EXIT2_IR         = 4'he,
		UPDATE_IR        = 4'hf
	} tap_state_t;

	localparam int IR_WIDTH = 4;

	typedef enum logic [IR_WIDTH-1:0] {
		INSTR_IDCODE     = 4'b0001,
		INSTR_CFG_ACCESS = 4'b0010,
		INSTR_BYPASS     = 4'b1111
	} jtag_instr_t;

	typedef logic [31:0] idcode_t;

	// Bit 0 must be set for a valid IDCODE
	localparam idcode_t DEFAULT_IDCODE = 32'h1D0C_0A5F;

endpackage

`default_nettype wire

//--- verilog/jtag_tap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_tap_ctrl
	import jtag_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  tck_rise_i,
	input  wire logic  tck_fall_i,
	input  wire logic  tms_i,
	input  wire logic  tdi_i,
	input  wire logic  trst_n_i,
	jtag_ctl_if.tap    ctl,
	output logic       ir_tdo_o,
	output logic       ir_sel_o
);
	// Fixed pattern loaded at Capture-IR
	localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001;

	tap_state_t            state_q;
	tap_state_t            state_d;
	logic [IR_WIDTH-1:0]   ir_shift_q;
	jtag_instr_t           instr_q;

	function automatic jtag_instr_t decode_instr(input logic [IR_WIDTH-1:0] code);
		case (code)
			INSTR_IDCODE,
			INSTR_CFG_ACCESS: decode_instr = jtag_instr_t'(code);
			default:          decode_instr = INSTR_BYPASS;
		endcase
	endfunction

	always_comb begin
		case (state_q)
			TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR:       state_d = tms_i ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_d = tms_i ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_d = tms_i ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_d = tms_i ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_d = tms_i ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_d = tms_i ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_d = tms_i ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_d = tms_i ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_d = tms_i ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_d = tms_i ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			default:          state_d = TEST_LOGIC_RESET;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= TEST_LOGIC_RESET;
		end else if (!trst_n_i) begin
			state_q <= TEST_LOGIC_RESET;
		end else if (tck_rise_i) begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ir_shift_q <= IR_CAPTURE;
			instr_q    <= INSTR_IDCODE;
		end else if (!trst_n_i || state_q == TEST_LOGIC_RESET) begin
			instr_q <= INSTR_IDCODE;
		end else if (tck_rise_i) begin
			case (state_q)
				CAPTURE_IR: ir_shift_q <= IR_CAPTURE;
				SHIFT_IR:   ir_shift_q <= {tdi_i, ir_shift_q[IR_WIDTH-1:1]};
				UPDATE_IR:  instr_q <= decode_instr(ir_shift_q);
				default: ;
			endcase
		end
	end

	assign ctl.tck_rise   = tck_rise_i;
	assign ctl.tck_fall   = tck_fall_i;
	assign ctl.tdi        = tdi_i;
	assign ctl.capture_dr = tck_rise_i && (state_q == CAPTURE_DR);
	assign ctl.shift_dr   = tck_rise_i && (state_q == SHIFT_DR);
	assign ctl.update_dr  = tck_rise_i && (state_q == UPDATE_DR);
	assign ctl.instr      = instr_q;

	// LSB goes out first, the chain picks it while shifting IR
	assign ir_tdo_o = ir_shift_q[0];
	assign ir_sel_o = (state_q == SHIFT_IR);

	// Each TCK rise gives a single-cycle strobe
	a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ctl.capture_dr || ctl.shift_dr || ctl.update_dr)
		|=> !(ctl.capture_dr || ctl.shift_dr || ctl.update_dr));

endmodule

`default_nettype wire
